// File: Bender.yml
package:
  name: la_soc

sources:
  - la_pkg.sv
  - la_alu.sv
  - la_decoder.sv
  - la_regfile.sv
  - la_core.sv
  - la_mem_arbiter.sv
  - la_apb_bridge.sv
  - la_ram.sv
  - la_soc.sv
  - target: test
    files:
      - la_soc_tb.sv

// File: la_alu.sv
`timescale 1ns/1ps

module la_alu (
    input  la_pkg::alu_op_e op,
    input  logic [31:0]     src1,
    input  logic [31:0]     src2,
    output logic [31:0]     result
);
    logic [4:0] sa;

    assign sa = src2[4:0];

    always_comb begin
        case (op)
            la_pkg::alu_add:  result = src1 + src2;
            la_pkg::alu_sub:  result = src1 - src2;
            la_pkg::alu_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            la_pkg::alu_sltu: result = {31'b0, src1 < src2};
            la_pkg::alu_and:  result = src1 & src2;
            la_pkg::alu_nor:  result = ~(src1 | src2);
            la_pkg::alu_or:   result = src1 | src2;
            la_pkg::alu_xor:  result = src1 ^ src2;
            la_pkg::alu_sll:  result = src1 << sa;
            la_pkg::alu_srl:  result = src1 >> sa;
            la_pkg::alu_sra:  result = $unsigned($signed(src1) >>> sa);
            la_pkg::alu_lui:  result = src2;      // the decoder has already shifted the immediate.
            default:          result = '0;
        endcase
    end

endmodule

// File: la_apb_bridge.sv
`timescale 1ns/1ps

module la_apb_bridge #(
    parameter int          mem_words = 1024,
    parameter logic [31:0] ctrl_addr = 32'hffff_fff0
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output la_pkg::mem_req_t req,
    input  la_pkg::mem_rsp_t rsp,
    output logic             run
);
    localparam int aw = $clog2(mem_words);

    logic access;
    logic is_ctrl;
    logic issued;     // the memory request of this access has been granted.
    logic wr_done;

    assign access = psel && penable;
    assign is_ctrl = paddr == ctrl_addr;

    assign req.valid = access && !is_ctrl && !issued;
    assign req.we = pwrite;
    assign req.addr = {{(30 - aw){1'b0}}, paddr[2 +: aw], 2'b00};  // wraps inside the memory.
    assign req.wdata = pwdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            issued <= 1'b0;
            wr_done <= 1'b0;
            run <= 1'b0;
        end else begin
            issued <= (req.valid && rsp.gnt) || (issued && !pready);
            wr_done <= req.valid && rsp.gnt && req.we;
            if (access && is_ctrl && pwrite) run <= pwdata[0];
        end
    end

    // the control register answers at once, memory once its access is done.
    assign pready = access && (is_ctrl || (pwrite ? wr_done : rsp.rvalid));
    assign prdata = is_ctrl ? {31'b0, run} : rsp.rdata;

    setup_first: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> $past(psel && !penable));

endmodule

// File: la_core.sv
`timescale 1ns/1ps

module la_core (
    input  logic             clk,
    input  logic             reset,
    input  logic             run,
    output la_pkg::mem_req_t mem_req,
    input  la_pkg::mem_rsp_t mem_rsp,
    output la_pkg::trace_t   trace
);
    typedef enum logic [2:0] {st_if, st_id, st_exe, st_mem, st_wb} state_e;

    state_e          state;
    la_pkg::decode_t dec;
    logic [31:0]     pc, npc, inst, rj_value, rkd_value, result;
    logic            wait_rsp;
    logic            held;
    logic [4:0]      raddr2;
    logic [31:0]     rdata1, rdata2;
    logic [31:0]     alu_src1, alu_src2, alu_result;
    logic            br_taken;
    logic [31:0]     br_target, id_next_pc;
    logic            id_to_if;
    logic            rf_we;
    logic [4:0]      wnum;

    la_decoder decoder_i (
        .inst (inst),
        .dec  (dec)
    );

    assign raddr2 = dec.src_reg_is_rd ? dec.rd : dec.rk;

    la_regfile regfile_i (
        .clk    (clk),
        .raddr1 (dec.rj),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (wnum),
        .wdata  (result)
    );

    // branches resolve in ID straight from the register file.
    always_comb begin
        case (dec.branch_kind)
            la_pkg::br_none: br_taken = 1'b0;
            la_pkg::br_beq:  br_taken = rdata1 == rdata2;
            la_pkg::br_bne:  br_taken = rdata1 != rdata2;
            default:         br_taken = 1'b1;
        endcase
    end

    assign br_target = ((dec.branch_kind == la_pkg::br_jirl) ? rdata1 : pc) + dec.br_offs;
    assign id_next_pc = br_taken ? br_target : pc + 32'd4;
    assign id_to_if = !dec.gr_we && !dec.store;   // b, beq, bne and unknown encodings.

    assign alu_src1 = dec.src1_is_pc ? pc : rj_value;
    assign alu_src2 = dec.src2_is_4 ? 32'd4 : (dec.src2_is_imm ? dec.imm : rkd_value);

    la_alu alu_i (
        .op     (dec.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    // a request left waiting for a grant is kept up even if run drops.
    assign mem_req.valid = !wait_rsp && ((state == st_if && (run || held)) || state == st_mem);
    assign mem_req.we = (state == st_mem) && dec.store;
    assign mem_req.addr = (state == st_mem) ? result : pc;
    assign mem_req.wdata = rkd_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_if;
            pc <= la_pkg::reset_pc;
            wait_rsp <= 1'b0;
            held <= 1'b0;
        end else begin
            wait_rsp <= mem_req.valid && mem_rsp.gnt && !mem_req.we;
            held <= mem_req.valid && !mem_rsp.gnt;
            case (state)
                st_if: if (mem_rsp.rvalid) state <= st_id;
                st_id: begin
                    if (id_to_if) begin
                        state <= st_if;
                        pc <= id_next_pc;
                    end else begin
                        state <= st_exe;
                    end
                end
                st_exe: state <= (dec.load || dec.store) ? st_mem : st_wb;
                st_mem: begin
                    if (dec.store && mem_rsp.gnt) begin
                        state <= st_if;
                        pc <= npc;
                    end else if (dec.load && mem_rsp.rvalid) begin
                        state <= st_wb;
                    end
                end
                st_wb: begin
                    state <= st_if;
                    pc <= npc;
                end
                default: state <= st_if;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_if && mem_rsp.rvalid) inst <= mem_rsp.rdata;
        if (state == st_id) begin
            rj_value <= rdata1;
            rkd_value <= rdata2;
            npc <= id_next_pc;
        end
        if (state == st_exe) result <= alu_result;
        if (state == st_mem && mem_rsp.rvalid) result <= mem_rsp.rdata;  // load data.
    end

    assign rf_we = (state == st_wb) && dec.gr_we;
    assign wnum = dec.dst_is_r1 ? 5'd1 : dec.rd;

    assign trace.pc = pc;
    assign trace.rf_we = rf_we;
    assign trace.wnum = wnum;
    assign trace.wdata = result;

    req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid && !mem_rsp.gnt |=> mem_req.valid && $stable(mem_req));

endmodule

// File: la_decoder.sv
`timescale 1ns/1ps

module la_decoder (
    input  logic [31:0]     inst,
    output la_pkg::decode_t dec
);
    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic        is_3r;
    logic        is_sh;
    logic        is_rr;
    logic        is_shift;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor;
    logic        inst_and, inst_or, inst_xor, inst_slli_w, inst_srli_w;
    logic        inst_srai_w, inst_addi_w, inst_ld_w, inst_st_w, inst_jirl;
    logic        inst_b, inst_bl, inst_beq, inst_bne, inst_lu12i_w;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];

    assign is_3r = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign is_sh = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = is_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = is_3r && (op_19_15 == 5'h02);
    assign inst_slt     = is_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = is_3r && (op_19_15 == 5'h05);
    assign inst_nor     = is_3r && (op_19_15 == 5'h08);
    assign inst_and     = is_3r && (op_19_15 == 5'h09);
    assign inst_or      = is_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = is_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = is_sh && (op_19_15 == 5'h01);
    assign inst_srli_w  = is_sh && (op_19_15 == 5'h09);
    assign inst_srai_w  = is_sh && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = op_31_26 == 6'h13;
    assign inst_b       = op_31_26 == 6'h14;
    assign inst_bl      = op_31_26 == 6'h15;
    assign inst_beq     = op_31_26 == 6'h16;
    assign inst_bne     = op_31_26 == 6'h17;
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];

    assign is_rr = inst_add_w | inst_sub_w | inst_slt | inst_sltu
                 | inst_nor | inst_and | inst_or | inst_xor;
    assign is_shift = inst_slli_w | inst_srli_w | inst_srai_w;

    always_comb begin
        dec = '0;                           // anything unmatched decodes as a no-op.
        dec.rd = inst[4:0];
        dec.rj = inst[9:5];
        dec.rk = inst[14:10];
        if (inst_sub_w) dec.alu_op = la_pkg::alu_sub;
        else if (inst_slt) dec.alu_op = la_pkg::alu_slt;
        else if (inst_sltu) dec.alu_op = la_pkg::alu_sltu;
        else if (inst_and) dec.alu_op = la_pkg::alu_and;
        else if (inst_nor) dec.alu_op = la_pkg::alu_nor;
        else if (inst_or) dec.alu_op = la_pkg::alu_or;
        else if (inst_xor) dec.alu_op = la_pkg::alu_xor;
        else if (inst_slli_w) dec.alu_op = la_pkg::alu_sll;
        else if (inst_srli_w) dec.alu_op = la_pkg::alu_srl;
        else if (inst_srai_w) dec.alu_op = la_pkg::alu_sra;
        else if (inst_lu12i_w) dec.alu_op = la_pkg::alu_lui;
        else dec.alu_op = la_pkg::alu_add;
        dec.src1_is_pc = inst_jirl | inst_bl;
        dec.src2_is_4 = inst_jirl | inst_bl;  // the link value is pc + 4.
        dec.src2_is_imm = is_shift | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w;
        dec.src_reg_is_rd = inst_beq | inst_bne | inst_st_w;
        dec.load = inst_ld_w;
        dec.store = inst_st_w;
        dec.gr_we = is_rr | is_shift | inst_addi_w | inst_ld_w
                  | inst_jirl | inst_bl | inst_lu12i_w;
        dec.dst_is_r1 = inst_bl;
        if (inst_b) dec.branch_kind = la_pkg::br_b;
        else if (inst_bl) dec.branch_kind = la_pkg::br_bl;
        else if (inst_beq) dec.branch_kind = la_pkg::br_beq;
        else if (inst_bne) dec.branch_kind = la_pkg::br_bne;
        else if (inst_jirl) dec.branch_kind = la_pkg::br_jirl;
        else dec.branch_kind = la_pkg::br_none;
        dec.imm = inst_lu12i_w ? {inst[24:5], 12'b0} : {{20{inst[21]}}, inst[21:10]};
        dec.br_offs = (inst_b | inst_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                         : {{14{inst[25]}}, inst[25:10], 2'b0};
    end

endmodule

// File: la_mem_arbiter.sv
`timescale 1ns/1ps

module la_mem_arbiter (
    input  logic             clk,
    input  logic             reset,
    input  la_pkg::mem_req_t core_req,
    output la_pkg::mem_rsp_t core_rsp,
    input  la_pkg::mem_req_t host_req,
    output la_pkg::mem_rsp_t host_rsp,
    output logic             ram_we,
    output logic [31:0]      ram_addr,
    output logic [31:0]      ram_wdata,
    input  logic [31:0]      ram_rdata
);
    la_pkg::mem_req_t sel;
    logic             gnt_core;
    logic             gnt_host;
    logic             last_host;
    logic             rd_core;
    logic             rd_host;

    // on a tie the requester that did not win last time goes first.
    assign gnt_host = host_req.valid && (!core_req.valid || !last_host);
    assign gnt_core = core_req.valid && !gnt_host;

    assign sel = gnt_host ? host_req : core_req;
    assign ram_we = (gnt_core || gnt_host) && sel.we;
    assign ram_addr = sel.addr;
    assign ram_wdata = sel.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_host <= 1'b0;
            rd_core <= 1'b0;
            rd_host <= 1'b0;
        end else begin
            if (gnt_core || gnt_host) last_host <= gnt_host;
            rd_core <= gnt_core && !core_req.we;   // the ram answers one cycle later.
            rd_host <= gnt_host && !host_req.we;
        end
    end

    assign core_rsp.gnt = gnt_core;
    assign core_rsp.rvalid = rd_core;
    assign core_rsp.rdata = rd_core ? ram_rdata : 32'd0;
    assign host_rsp.gnt = gnt_host;
    assign host_rsp.rvalid = rd_host;
    assign host_rsp.rdata = rd_host ? ram_rdata : 32'd0;

    // both requesters hold valid, so neither waits past a single lost round.
    core_wait: assert property (@(posedge clk) disable iff (reset)
        core_req.valid && !gnt_core |=> gnt_core);
    host_wait: assert property (@(posedge clk) disable iff (reset)
        host_req.valid && !gnt_host |=> gnt_host);

endmodule

// File: la_pkg.sv
package la_pkg;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {br_none, br_b, br_bl, br_beq, br_bne, br_jirl} branch_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_4;
        logic        src_reg_is_rd;   // beq, bne and st.w read rd as the second operand.
        logic        load;
        logic        store;
        logic        gr_we;
        branch_e     branch_kind;
        logic        dst_is_r1;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [31:0] br_offs;
    } decode_t;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [31:0] addr;            // byte address.
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        gnt;
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } trace_t;

endpackage

// File: la_ram.sv
`timescale 1ns/1ps

module la_ram #(
    parameter int mem_words = 1024
) (
    input  logic        clk,
    input  logic        we,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    localparam int aw = $clog2(mem_words);

    logic [31:0] mem [mem_words];

    always_ff @(posedge clk) begin
        if (we) mem[addr[2 +: aw]] <= wdata;
        rdata <= mem[addr[2 +: aw]];   // upper address bits are ignored.
    end

endmodule

// File: la_regfile.sv
`timescale 1ns/1ps

module la_regfile (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    logic [31:0] rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

// File: la_soc.f
la_pkg.sv
la_alu.sv
la_decoder.sv
la_regfile.sv
la_core.sv
la_mem_arbiter.sv
la_apb_bridge.sv
la_ram.sv
la_soc.sv
la_soc_tb.sv

// File: la_soc.sv
`timescale 1ns/1ps

module la_soc #(
    parameter int          mem_words = 1024,
    parameter logic [31:0] ctrl_addr = 32'hffff_fff0
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [31:0]    paddr,
    input  logic [31:0]    pwdata,
    output logic [31:0]    prdata,
    output logic           pready,
    output la_pkg::trace_t trace
);
    la_pkg::mem_req_t core_req;
    la_pkg::mem_rsp_t core_rsp;
    la_pkg::mem_req_t host_req;
    la_pkg::mem_rsp_t host_rsp;
    logic             run;
    logic             ram_we;
    logic [31:0]      ram_addr;
    logic [31:0]      ram_wdata;
    logic [31:0]      ram_rdata;

    la_core core_i (
        .clk     (clk),
        .reset   (reset),
        .run     (run),
        .mem_req (core_req),
        .mem_rsp (core_rsp),
        .trace   (trace)
    );

    la_apb_bridge #(
        .mem_words (mem_words),
        .ctrl_addr (ctrl_addr)
    ) bridge_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .req     (host_req),
        .rsp     (host_rsp),
        .run     (run)
    );

    la_mem_arbiter arbiter_i (
        .clk       (clk),
        .reset     (reset),
        .core_req  (core_req),
        .core_rsp  (core_rsp),
        .host_req  (host_req),
        .host_rsp  (host_rsp),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    la_ram #(
        .mem_words (mem_words)
    ) ram_i (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// File: la_soc_tb.sv
`timescale 1ns/1ps

module la_soc_tb;
    localparam int          mem_words  = 1024;
    localparam logic [31:0] ctrl_addr  = 32'hffff_fff0;
    localparam logic [31:0] base       = 32'h1c00_0000;
    localparam int          loop_n     = 300;
    // loading, host traffic and the program need under 1000 cycles, so this leaves a wide margin.
    localparam int          max_cycles = 4000;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  wnum;
        logic [31:0] wdata;
        logic [2:0]  test;
    } exp_t;

    logic           clk;
    logic           reset;
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [31:0]    paddr;
    logic [31:0]    pwdata;
    logic [31:0]    prdata;
    logic           pready;
    la_pkg::trace_t trace;

    logic [31:0] shadow [mem_words];   // what the host expects to read back.
    logic [31:0] host_expect;
    logic        run_shadow;
    logic [31:0] prog [$];
    logic [31:0] emit_pc;
    exp_t        expq [$];
    exp_t        exp_head;
    logic        exp_any;
    logic        stopped;
    int          cur_test;
    int          errors [6];
    int          cycles;
    int          writes_seen;
    int          reads_seen;
    string       names [6] = '{"idle", "alu", "load_store", "branch", "host_traffic", "stop"};

    la_soc #(
        .mem_words (mem_words),
        .ctrl_addr (ctrl_addr)
    ) dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .trace   (trace)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // the queue head is the next register write the core has to retire.
    always @(negedge clk) begin
        if (!reset && trace.rf_we) begin
            writes_seen++;
            if (expq.size() > 0) void'(expq.pop_front());
        end
        exp_any = expq.size() > 0;
        exp_head = exp_any ? expq[0] : '0;
    end

    trace_match: assert property (@(negedge clk) disable iff (reset)
        trace.rf_we && exp_any |-> trace.pc == exp_head.pc && trace.wnum == exp_head.wnum
            && trace.wdata == exp_head.wdata)
    else begin
        errors[$sampled(exp_head.test)]++;
        $display("Mismatch %s: expected pc %h r%0d = %h, actual pc %h r%0d = %h",
                 names[$sampled(exp_head.test)], $sampled(exp_head.pc),
                 $sampled(exp_head.wnum), $sampled(exp_head.wdata),
                 trace.pc, trace.wnum, trace.wdata);
    end

    write_expected: assert property (@(negedge clk) disable iff (reset)
        trace.rf_we |-> exp_any && !stopped)
    else begin
        errors[cur_test]++;
        $display("test %s: the core wrote r%0d at pc %h where no write was due",
                 names[cur_test], trace.wnum, trace.pc);
    end

    ready_idle: assert property (@(negedge clk) disable iff (reset) !psel |-> !pready)
    else begin
        errors[cur_test]++;
        $display("test %s: pready is high with no APB transfer", names[cur_test]);
    end

    host_read: assert property (@(negedge clk) disable iff (reset)
        psel && penable && pready && !pwrite |-> prdata == host_expect)
    else begin
        errors[cur_test]++;
        $display("Mismatch %s: expected %h, actual %h", names[cur_test], host_expect, prdata);
    end

    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[31:2] % mem_words);
    endfunction

    // 3R, shift, 12-bit immediate and 16-bit offset forms share one field layout.
    function automatic logic [31:0] regs_form(input logic [31:0] code, input logic [15:0] field,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return code | {6'b0, field, rj, rd};
    endfunction

    function automatic logic [31:0] upper_form(input logic [19:0] imm, input logic [4:0] rd);
        return 32'h1400_0000 | {7'b0, imm, rd};
    endfunction

    function automatic logic [31:0] jump_form(input logic [31:0] code, input logic [25:0] offs);
        return code | {6'b0, offs[15:0], offs[25:16]};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic apb_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] data);
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = is_write;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        if (addr == ctrl_addr) run_shadow = data[0];
        else shadow[word_index(addr)] = data;
        apb_access(1'b1, addr, data);
    endtask

    task automatic read_word(input logic [31:0] addr);
        host_expect = (addr == ctrl_addr) ? {31'b0, run_shadow} : shadow[word_index(addr)];
        reads_seen++;
        apb_access(1'b0, addr, 32'd0);
    endtask

    task automatic emit(input logic [31:0] inst, input logic wr, input logic [4:0] rd,
                        input logic [31:0] value, input int test);
        prog.push_back(inst);
        if (wr) expq.push_back(exp_t'{emit_pc, rd, value, 3'(test)});
        emit_pc = emit_pc + 32'd4;
    endtask

    task automatic build_program();
        logic [19:0] hi_a;
        logic [19:0] hi_b;
        logic [11:0] lo_a;
        logic [11:0] lo_b;
        logic [4:0]  sa;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] loop_pc;
        int          k;
        hi_a = 20'($urandom);
        hi_b = 20'($urandom);
        lo_a = 12'($urandom);
        lo_b = 12'($urandom);
        sa = 5'($urandom);
        a = {hi_a, 12'b0} + {{20{lo_a[11]}}, lo_a};
        b = {hi_b, 12'b0} + {{20{lo_b[11]}}, lo_b};
        emit_pc = base;
        emit(upper_form(hi_a, 5'd4), 1'b1, 5'd4, {hi_a, 12'b0}, 1);
        emit(regs_form(32'h0280_0000, lo_a, 5'd4, 5'd4), 1'b1, 5'd4, a, 1);
        emit(upper_form(hi_b, 5'd5), 1'b1, 5'd5, {hi_b, 12'b0}, 1);
        emit(regs_form(32'h0280_0000, lo_b, 5'd5, 5'd5), 1'b1, 5'd5, b, 1);
        emit(regs_form(32'h0010_0000, 5'd5, 5'd4, 5'd6), 1'b1, 5'd6, a + b, 1);
        emit(regs_form(32'h0011_0000, 5'd5, 5'd4, 5'd7), 1'b1, 5'd7, a - b, 1);
        emit(regs_form(32'h0012_0000, 5'd5, 5'd4, 5'd8), 1'b1, 5'd8,
             ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, 1);
        emit(regs_form(32'h0012_8000, 5'd5, 5'd4, 5'd9), 1'b1, 5'd9, (a < b) ? 32'd1 : 32'd0, 1);
        emit(regs_form(32'h0014_8000, 5'd5, 5'd4, 5'd10), 1'b1, 5'd10, a & b, 1);
        emit(regs_form(32'h0014_0000, 5'd5, 5'd4, 5'd11), 1'b1, 5'd11, ~(a | b), 1);
        emit(regs_form(32'h0015_0000, 5'd5, 5'd4, 5'd12), 1'b1, 5'd12, a | b, 1);
        emit(regs_form(32'h0015_8000, 5'd5, 5'd4, 5'd13), 1'b1, 5'd13, a ^ b, 1);
        emit(regs_form(32'h0040_8000, sa, 5'd4, 5'd14), 1'b1, 5'd14, a << sa, 1);
        emit(regs_form(32'h0044_8000, sa, 5'd4, 5'd15), 1'b1, 5'd15, a >> sa, 1);
        emit(regs_form(32'h0048_8000, sa, 5'd4, 5'd16), 1'b1, 5'd16,
             (a >> sa) | (a[31] ? ~(32'hffff_ffff >> sa) : 32'd0), 1);
        // st.w r6 to 0x604, then ld.w of the same word into r18.
        emit(regs_form(32'h0280_0000, 12'h600, 5'd0, 5'd17), 1'b1, 5'd17, 32'h600, 2);
        emit(regs_form(32'h2980_0000, 12'h004, 5'd17, 5'd6), 1'b0, 5'd0, 32'd0, 2);
        emit(regs_form(32'h2880_0000, 12'h004, 5'd17, 5'd18), 1'b1, 5'd18, a + b, 2);
        shadow[word_index(32'h604)] = a + b;
        emit(regs_form(32'h0280_0000, 12'd5, 5'd0, 5'd19), 1'b1, 5'd19, 32'd5, 3);
        emit(regs_form(32'h0280_0000, 12'd5, 5'd0, 5'd21), 1'b1, 5'd21, 32'd5, 3);
        emit(regs_form(32'h5800_0000, 16'd2, 5'd19, 5'd21), 1'b0, 5'd0, 32'd0, 3);
        emit(regs_form(32'h0280_0000, 12'd1, 5'd0, 5'd22), 1'b0, 5'd0, 32'd0, 3);  // skipped.
        emit(regs_form(32'h5c00_0000, 16'd2, 5'd19, 5'd0), 1'b0, 5'd0, 32'd0, 3);
        emit(regs_form(32'h0280_0000, 12'd2, 5'd0, 5'd22), 1'b0, 5'd0, 32'd0, 3);  // skipped.
        emit(regs_form(32'h5800_0000, 16'd2, 5'd19, 5'd0), 1'b0, 5'd0, 32'd0, 3);
        emit(regs_form(32'h0280_0000, 12'd3, 5'd0, 5'd22), 1'b1, 5'd22, 32'd3, 3);
        emit(regs_form(32'h5c00_0000, 16'd2, 5'd19, 5'd21), 1'b0, 5'd0, 32'd0, 3);
        emit(regs_form(32'h0280_0000, 12'd4, 5'd0, 5'd23), 1'b1, 5'd23, 32'd4, 3);
        emit(jump_form(32'h5400_0000, 26'd2), 1'b1, 5'd1, emit_pc + 32'd4, 3);     // bl.
        emit(regs_form(32'h0280_0000, 12'd5, 5'd0, 5'd24), 1'b0, 5'd0, 32'd0, 3);
        emit(upper_form(base[31:12], 5'd25), 1'b1, 5'd25, base, 3);
        emit(regs_form(32'h4c00_0000, 16'((emit_pc + 32'd8 - base) >> 2), 5'd25, 5'd26),
             1'b1, 5'd26, emit_pc + 32'd4, 3);
        emit(regs_form(32'h0280_0000, 12'd6, 5'd0, 5'd24), 1'b0, 5'd0, 32'd0, 3);
        // a counting loop keeps the core busy until run is cleared.
        emit(regs_form(32'h0280_0000, 12'd0, 5'd0, 5'd20), 1'b1, 5'd20, 32'd0, 5);
        loop_pc = emit_pc;
        emit(regs_form(32'h0280_0000, 12'd1, 5'd20, 5'd20), 1'b0, 5'd0, 32'd0, 5);
        emit(jump_form(32'h5000_0000, 26'h3ff_ffff), 1'b0, 5'd0, 32'd0, 5);
        for (k = 1; k <= loop_n; k++) expq.push_back(exp_t'{loop_pc, 5'd20, 32'(k), 3'd5});
    endtask

    task automatic print_result(input int idx);
        if (errors[idx] == 0) $display("test %0d %s: ok", idx + 1, names[idx]);
        else $display("test %0d %s: %0d errors", idx + 1, names[idx], errors[idx]);
    endtask

    initial begin
        int          i;
        int          failed_tests;
        int          total_errors;
        logic [31:0] addr;
        void'($urandom(32'h71b2));
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 32'd0;
        pwdata = 32'd0;
        host_expect = 32'd0;
        run_shadow = 1'b0;
        stopped = 1'b0;
        exp_any = 1'b0;
        exp_head = '0;
        cur_test = 0;
        cycles = 0;
        writes_seen = 0;
        reads_seen = 0;
        foreach (errors[j]) errors[j] = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        read_word(ctrl_addr);
        for (i = 0; i < 8; i++) begin
            write_word(32'h400 + 4 * i, $urandom);
            wait_cycles($urandom % 4);
        end
        for (i = 0; i < 8; i++) read_word(32'h400 + 4 * i);
        wait_cycles(20);   // run is still low, so nothing may retire.
        print_result(0);

        build_program();
        for (i = 0; i < prog.size(); i++) write_word(base + 4 * i, prog[i]);
        write_word(ctrl_addr, 32'd1);

        cur_test = 4;
        for (i = 0; i < 12; i++) begin
            addr = 32'h400 + 4 * ($urandom % 8);
            if ($urandom % 2) write_word(addr, $urandom);
            else read_word(addr);
            wait_cycles($urandom % 4);
        end
        print_result(4);

        while (expq.size() > loop_n - 1) @(negedge clk);   // the program reached its loop.
        print_result(1);
        print_result(3);
        cur_test = 2;
        read_word(32'h604);
        print_result(2);

        cur_test = 5;
        write_word(ctrl_addr, 32'd0);
        wait_cycles(12);   // lets the instruction in flight retire.
        #1;
        stopped = 1'b1;
        wait_cycles(40);
        print_result(5);

        failed_tests = 0;
        total_errors = 0;
        for (i = 0; i < 6; i++) begin
            total_errors += errors[i];
            if (errors[i] != 0) failed_tests++;
        end
        $display("6 tests, %0d failed, %0d writebacks and %0d host reads seen, %0d errors",
                 failed_tests, writes_seen, reads_seen, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
